//--- dv/cache_assertions.sv
module cache_assertions (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   tag_write,
	input logic                   data_write,
	input logic                   cache_enable,
	input cache_pkg::cache_addr_t read_address,
	input cache_pkg::cache_addr_t write_address,
	input cache_pkg::data_word_t  data_out,
	input logic                   cache_miss
);

	logic plain_read;	// Enabled lookup with no write strobe

	assign plain_read = cache_enable & ~tag_write & ~data_write;

	no_miss_when_disabled: assert property (
		@(posedge clk) !cache_enable |-> !cache_miss
	) else $error("cache_miss is high while cache_enable is low");

	data_out_known: assert property (
		@(posedge clk) disable iff (!rst_n) !$isunknown(data_out)
	) else $error("data_out has unknown bits");

	// Read of the line just filled with the same tag
	fill_then_hit: assert property (
		@(posedge clk) disable iff (!rst_n)
		($past(tag_write) && $past(rst_n) && plain_read
			&& read_address.tag == $past(write_address.tag)
			&& read_address.index == $past(write_address.index)) |-> !cache_miss
	) else $error("Read right after a tag fill of the same address missed");

endmodule

bind cache cache_assertions i_assertions (
	.clk           (clk),
	.rst_n         (rst_n),
	.tag_write     (tag_write),
	.data_write    (data_write),
	.cache_enable  (cache_enable),
	.read_address  (read_address),
	.write_address (write_address),
	.data_out      (data_out),
	.cache_miss    (cache_miss)
);

//--- dv/cache_checker.sv
module cache_checker (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   tag_write,
	input  logic                   data_write,
	input  logic                   cache_enable,
	input  cache_pkg::cache_addr_t read_address,
	input  cache_pkg::cache_addr_t write_address,
	input  cache_pkg::data_word_t  data_in,
	input  cache_pkg::data_word_t  data_out,
	input  logic                   cache_miss,
	output int                     error_count,
	output int                     check_count
);

	import cache_pkg::*;

	typedef struct packed {
		logic       miss;
		data_word_t data;
	} expect_t;

	// Model of the stored state
	logic             model_valid [NUM_LINES];
	logic [TAG_W-1:0] model_tag [NUM_LINES];
	data_word_t       model_data [NUM_LINES][WORDS_PER_LINE];

	// Expected outputs for the inputs of one cycle against the model
	function automatic expect_t predict_outputs(
		input logic        enable,
		input logic        tw,
		input logic        dw,
		input cache_addr_t ra,
		input cache_addr_t wa
	);
		expect_t     result;
		cache_addr_t access;
		logic        line_hit;
		access = (tw || dw) ? wa : ra;	// Write strobes steer the lookup
		line_hit = model_valid[access.index] && (model_tag[access.index] == access.tag);
		result.miss = enable && !line_hit;
		result.data = model_data[access.index][access.offset];
		return result;
	endfunction

	always @(posedge clk) begin
		expect_t expected;
		int      new_errors;
		new_errors = 0;
		if (!rst_n) begin
			for (int l = 0; l < NUM_LINES; l++) begin
				model_valid[l] = 1'b0;
				model_tag[l] = '0;
				for (int w = 0; w < WORDS_PER_LINE; w++) begin
					model_data[l][w] = '0;
				end
			end
			error_count <= 0;
			check_count <= 0;
		end else begin
			expected = predict_outputs(cache_enable, tag_write, data_write, read_address,
				write_address);
			// Expected miss is low while the cache is disabled
			if (cache_miss !== expected.miss) begin
				$display("Error at time %0t: cache_miss expected %0b, got %0b",
					$time, expected.miss, cache_miss);
				new_errors++;
			end
			if (cache_enable && !tag_write && !data_write && data_out !== expected.data) begin
				$display("Error at time %0t: data_out expected 16'h%h, got 16'h%h",
					$time, expected.data, data_out);
				new_errors++;
			end
			// This edge's writes land after the compare
			if (tag_write) begin
				model_valid[write_address.index] = 1'b1;
				model_tag[write_address.index] = write_address.tag;
			end
			if (data_write) begin
				model_data[write_address.index][write_address.offset] = data_in;
			end
			error_count <= error_count + new_errors;
			check_count <= check_count + 1;
		end
	end

endmodule

//--- dv/cache_tb.sv
module cache_tb;

	import cache_pkg::*;

	localparam int SEED          = 32'h9bbd_2a0f;
	localparam int RESET_CYCLES  = 16;
	localparam int CHECK_TIMEOUT = 20;	// Cycles allowed for the checker to catch up
	localparam int READ_CYCLES   = 24;
	localparam int IDLE_TRAFFIC  = 40;
	localparam int MIX_CYCLES    = 300;

	localparam logic [TAG_W-1:0]   TAG_A  = 5'h0a;
	localparam logic [TAG_W-1:0]   TAG_B  = 5'h15;
	localparam logic [INDEX_W-1:0] LINE_A = 7'h21;

	logic        clk;
	logic        rst_n;
	logic        tag_write;
	logic        data_write;
	logic        cache_enable;
	cache_addr_t read_address;
	cache_addr_t write_address;
	data_word_t  data_in;
	data_word_t  data_out;
	logic        cache_miss;

	int error_count;
	int check_count;
	int start_errors;
	int tests_run;
	int tests_failed;
	logic timed_out;

	cache i_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.tag_write     (tag_write),
		.data_write    (data_write),
		.cache_enable  (cache_enable),
		.read_address  (read_address),
		.write_address (write_address),
		.data_in       (data_in),
		.data_out      (data_out),
		.cache_miss    (cache_miss)
	);

	cache_checker i_checker (
		.clk           (clk),
		.rst_n         (rst_n),
		.tag_write     (tag_write),
		.data_write    (data_write),
		.cache_enable  (cache_enable),
		.read_address  (read_address),
		.write_address (write_address),
		.data_in       (data_in),
		.data_out      (data_out),
		.cache_miss    (cache_miss),
		.error_count   (error_count),
		.check_count   (check_count)
	);

	always #50 clk = ~clk;

	function automatic cache_addr_t make_addr(
		input logic [TAG_W-1:0]    tag,
		input logic [INDEX_W-1:0]  index,
		input logic [OFFSET_W-1:0] offset
	);
		cache_addr_t a;
		a = '0;
		a.tag = tag;
		a.index = index;
		a.offset = offset;
		return a;
	endfunction

	function automatic cache_addr_t rand_addr();
		logic [31:0] r;
		r = $urandom;
		return r[ADDR_W-1:0];
	endfunction

	function automatic data_word_t rand_word();
		logic [31:0] r;
		r = $urandom;
		return r[DATA_W-1:0];
	endfunction

	task automatic drive_cycle(
		input logic        tw,
		input logic        dw,
		input logic        en,
		input cache_addr_t ra,
		input cache_addr_t wa,
		input data_word_t  din
	);
		@(posedge clk);
		tag_write     <= tw;
		data_write    <= dw;
		cache_enable  <= en;
		read_address  <= ra;
		write_address <= wa;
		data_in       <= din;
	endtask

	task automatic read_line_words(input logic [TAG_W-1:0] tag, input logic [INDEX_W-1:0] index);
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			drive_cycle(1'b0, 1'b0, 1'b1, make_addr(tag, index, OFFSET_W'(w)), '0, '0);
		end
	endtask

	// Counters move by NBA, so two more compares cover the cycle driven last
	task automatic wait_checked();
		int target;
		int waited;
		target = check_count + 2;
		waited = 0;
		while (check_count < target && waited < CHECK_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (check_count < target) begin
			timed_out = 1'b1;
			$display("Timeout: the checker stopped comparing DUT outputs");
		end
	endtask

	task automatic end_test(input int num, input string name);
		int errs;
		drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, '0);
		wait_checked();
		errs = error_count - start_errors;
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("Test %0d %s: %s (%0d errors)", num, name, (errs == 0) ? "ok" : "FAILED", errs);
		start_errors = error_count;
	endtask

	initial begin
		logic [31:0] r;
		clk = 1'b0;
		rst_n = 1'b0;
		tag_write = 1'b0;
		data_write = 1'b0;
		cache_enable = 1'b0;
		read_address = '0;
		write_address = '0;
		data_in = '0;
		tests_run = 0;
		tests_failed = 0;
		start_errors = 0;
		timed_out = 1'b0;
		void'($urandom(SEED));

		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		// Nothing is valid after reset
		for (int n = 0; n < READ_CYCLES; n++) begin
			drive_cycle(1'b0, 1'b0, 1'b1, rand_addr(), '0, '0);
		end
		end_test(1, "reset reads");

		// Fill shares its cycle with the first word write
		drive_cycle(1'b1, 1'b1, 1'b1, '0, make_addr(TAG_A, LINE_A, '0), rand_word());
		for (int w = 1; w < WORDS_PER_LINE; w++) begin
			drive_cycle(1'b0, 1'b1, 1'b1, '0, make_addr(TAG_A, LINE_A, OFFSET_W'(w)), rand_word());
		end
		read_line_words(TAG_A, LINE_A);
		end_test(2, "fill and word writes");

		// New tag at the same line, read straight after its fill
		read_line_words(TAG_B, LINE_A);
		drive_cycle(1'b1, 1'b0, 1'b1, '0, make_addr(TAG_B, LINE_A, '0), '0);
		read_line_words(TAG_B, LINE_A);
		read_line_words(TAG_A, LINE_A);
		end_test(3, "tag replace");

		// Writes miss on lines that hold another tag
		drive_cycle(1'b0, 1'b1, 1'b1, '0, make_addr(5'h03, 7'h50, 3'h2), rand_word());
		drive_cycle(1'b0, 1'b1, 1'b1, '0, make_addr(TAG_B, LINE_A, 3'h3), rand_word());
		drive_cycle(1'b0, 1'b1, 1'b1, '0, make_addr(TAG_A, LINE_A, 3'h4), rand_word());
		read_line_words(TAG_B, LINE_A);
		end_test(4, "write miss");

		// Random traffic with the miss flag gated off
		for (int n = 0; n < IDLE_TRAFFIC; n++) begin
			r = $urandom;
			drive_cycle(r[0] & r[1], r[2], 1'b0, rand_addr(), rand_addr(), rand_word());
		end
		end_test(5, "cache disabled");

		// Few tags and lines so fills and hits collide often
		for (int n = 0; n < MIX_CYCLES; n++) begin
			r = $urandom;
			drive_cycle(r[7] & r[8], r[9], r[11:10] != 2'b00,
				make_addr({3'b000, r[13:12]}, {5'b00010, r[15:14]}, r[18:16]),
				make_addr({3'b000, r[1:0]}, {5'b00010, r[3:2]}, r[6:4]), rand_word());
		end
		end_test(6, "random mix");

		$display("Summary: %0d tests run, %0d failed, %0d errors, %0d cycles checked",
			tests_run, tests_failed, error_count, check_count);
		if (tests_failed != 0 || timed_out) begin
			$display("Regression failed");
		end else begin
			$display("Regression passed");
		end
		$finish;
	end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
	--top-module cache_tb \
	-f tb.f \
	-o cache_sim

status=0
./obj_dir/cache_sim > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
	echo "Simulation reported failure, see $LOG"
	exit 1
fi

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

exit 0

//--- tb.f
verilog/cache_pkg.sv
verilog/cache_tag_array.sv
verilog/cache_data_array.sv
verilog/cache.sv
dv/cache_checker.sv
dv/cache_assertions.sv
dv/cache_tb.sv

//--- verilog/cache.sv
module cache (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   tag_write,
	input  logic                   data_write,
	input  logic                   cache_enable,
	input  cache_pkg::cache_addr_t read_address,
	input  cache_pkg::cache_addr_t write_address,
	input  cache_pkg::data_word_t  data_in,
	output cache_pkg::data_word_t  data_out,
	output logic                   cache_miss
);

	import cache_pkg::*;

	cache_addr_t access_addr;	// Address the lookup works on
	logic        write_access;
	logic        hit;

	// Write fields
	logic [INDEX_W-1:0]  write_index;
	logic [OFFSET_W-1:0] write_offset;
	logic [TAG_W-1:0]    write_tag;

	// Access fields
	logic [TAG_W-1:0]    access_tag;
	logic [INDEX_W-1:0]  access_index;
	logic [OFFSET_W-1:0] access_offset;

	// Either strobe moves the lookup onto the write address
	assign write_access = data_write | tag_write;

	always_comb begin
		if (write_access) begin
			access_addr = write_address;
		end else begin
			access_addr = read_address;
		end
	end

	// Byte select takes no part in lookup or storage
	assign access_tag    = access_addr.tag;
	assign access_index  = access_addr.index;
	assign access_offset = access_addr.offset;

	assign write_tag    = write_address.tag;
	assign write_index  = write_address.index;
	assign write_offset = write_address.offset;

	cache_tag_array i_tag_array (
		.clk          (clk),
		.rst_n        (rst_n),
		.write        (tag_write),
		.write_index  (write_index),
		.write_tag    (write_tag),
		.lookup_index (access_index),
		.lookup_tag   (access_tag),
		.hit          (hit)
	);

	cache_data_array i_data_array (
		.clk          (clk),
		.rst_n        (rst_n),
		.write        (data_write),
		.write_index  (write_index),
		.write_offset (write_offset),
		.write_data   (data_in),
		.read_index   (access_index),
		.read_offset  (access_offset),
		.read_data    (data_out)
	);

	// Write accesses miss too when the line holds another tag
	assign cache_miss = cache_enable & ~hit;

endmodule

//--- verilog/cache_data_array.sv
module cache_data_array (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           write,
	input  logic [cache_pkg::INDEX_W-1:0]  write_index,
	input  logic [cache_pkg::OFFSET_W-1:0] write_offset,
	input  cache_pkg::data_word_t          write_data,
	input  logic [cache_pkg::INDEX_W-1:0]  read_index,
	input  logic [cache_pkg::OFFSET_W-1:0] read_offset,
	output cache_pkg::data_word_t          read_data
);

	import cache_pkg::*;

	// Line by word storage
	data_word_t words [NUM_LINES][WORDS_PER_LINE];

	// Words of the line being read
	data_word_t read_line [WORDS_PER_LINE];

	// Every word is cleared under reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int l = 0; l < NUM_LINES; l++) begin
				for (int w = 0; w < WORDS_PER_LINE; w++) begin
					words[l][w] <= '0;
				end
			end
		end else if (write) begin
			words[write_index][write_offset] <= write_data;	// One word per cycle
		end
	end

	// Line select first, then the word within it
	always_comb begin
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			read_line[w] = words[read_index][w];
		end
	end

	assign read_data = read_line[read_offset];

endmodule

//--- verilog/cache_pkg.sv
package cache_pkg;

	// Address and data word widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;

	// Address fields from high to low are tag, line index, word offset and byte select
	localparam int TAG_W    = 5;
	localparam int INDEX_W  = 7;
	localparam int OFFSET_W = 3;
	localparam int BYTE_W   = ADDR_W - TAG_W - INDEX_W - OFFSET_W;	// Ignored by lookups

	// Geometry follows from the field widths
	localparam int NUM_LINES      = 1 << INDEX_W;		// 128 lines
	localparam int WORDS_PER_LINE = 1 << OFFSET_W;		// 8 words per line

	// Tag entry takes 8 bits in all
	localparam int RSVD_W = 2;

	typedef struct packed {
		logic [TAG_W-1:0]    tag;
		logic [INDEX_W-1:0]  index;
		logic [OFFSET_W-1:0] offset;
		logic [BYTE_W-1:0]   byte_sel;
	} cache_addr_t;

	typedef struct packed {
		logic              valid;
		logic [RSVD_W-1:0] reserved;	// Written as zero
		logic [TAG_W-1:0]  tag;
	} tag_entry_t;

	typedef logic [DATA_W-1:0] data_word_t;

	// Entry held by a line after reset
	localparam tag_entry_t EMPTY_ENTRY = '0;

	// Entry stored by a tag fill
	function automatic tag_entry_t fill_entry(input logic [TAG_W-1:0] tag);
		tag_entry_t entry;
		entry.valid    = 1'b1;
		entry.reserved = '0;
		entry.tag      = tag;
		return entry;
	endfunction

	// A stored entry hits only when valid and holding the same tag
	function automatic logic entry_hit(
		input tag_entry_t       entry,
		input logic [TAG_W-1:0] tag
	);
		logic same_tag;
		same_tag = (entry.tag == tag);
		return entry.valid & same_tag;
	endfunction

endpackage

//--- verilog/cache_tag_array.sv
module cache_tag_array (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          write,
	input  logic [cache_pkg::INDEX_W-1:0] write_index,
	input  logic [cache_pkg::TAG_W-1:0]   write_tag,
	input  logic [cache_pkg::INDEX_W-1:0] lookup_index,
	input  logic [cache_pkg::TAG_W-1:0]   lookup_tag,
	output logic                          hit
);

	import cache_pkg::*;

	// One entry per line
	tag_entry_t entries [NUM_LINES];

	tag_entry_t lookup_entry;
	tag_entry_t new_entry;

	// Valid bit set, reserved bits zero
	assign new_entry = fill_entry(write_tag);

	// Reset invalidates every line, a fill overwrites one entry
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_LINES; i++) begin
				entries[i] <= EMPTY_ENTRY;
			end
		end else if (write) begin
			entries[write_index] <= new_entry;
		end
	end

	// Lookup reads stored state, so a fill shows up right after its edge
	assign lookup_entry = entries[lookup_index];

	assign hit = entry_hit(lookup_entry, lookup_tag);

endmodule
